// File: src/lsu_defs.svh
// bus size codes and widths for the load/store unit, include where the raw values are needed
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ========================================
// widths
// ========================================

// one bus or register word
`define LSU_DATA_W 32

// register index, x0 to x31
`define LSU_REG_W 5

// address bits below the word boundary, select the byte lane
`define LSU_ADDR_LSB_W 2

// width of the AHB hsize field
`define LSU_HSIZE_W 3

// ========================================
// AHB hsize codes
// ========================================

`define LSU_HSIZE_BYTE 3'd0
`define LSU_HSIZE_HALF 3'd1
`define LSU_HSIZE_WORD 3'd2

`endif

// File: src/lsu_pkg.sv
// shared types of the load/store unit, imported by every module of the data path
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

   // ========================================
   // vector types
   // ========================================

   // data word on hwdatad / hrdatad and on the write-back port
   typedef logic [`LSU_DATA_W-1:0] data_t;

   // byte address on haddrd
   typedef logic [`LSU_DATA_W-1:0] addr_t;

   // register file index for load destination and store source
   typedef logic [`LSU_REG_W-1:0] reg_idx_t;

   // low address bits, pick the byte lane inside a word
   typedef logic [`LSU_ADDR_LSB_W-1:0] lane_t;

   // ========================================
   // access size
   // ========================================

   // encoded as the AHB hsize value so it drives hsized directly
   typedef enum logic [`LSU_HSIZE_W-1:0] {
      MEM_BYTE = `LSU_HSIZE_BYTE,
      MEM_HALF = `LSU_HSIZE_HALF,
      MEM_WORD = `LSU_HSIZE_WORD
   } mem_size_e;

endpackage

`default_nettype wire

// File: src/lsu_store_align.sv
// store data lane placement, combinational, used by lsu_top ahead of the hwdatad register
`default_nettype none

module lsu_store_align (
   input  lsu_pkg::mem_size_e req_size,
   input  lsu_pkg::lane_t     lane,
   input  lsu_pkg::data_t     req_wdata,
   input  logic               fwd_hit,
   input  lsu_pkg::data_t     fwd_data,
   output lsu_pkg::data_t     aligned_wdata
);

   import lsu_pkg::*;

   data_t store_src;

   // ========================================
   // source selection
   // ========================================

   // load result still on the bus replaces the stale register value
   assign store_src = fwd_hit ? fwd_data : req_wdata;

   // ========================================
   // lane placement
   // ========================================

   always_comb begin
      case (req_size)
         MEM_BYTE: begin
            // low byte goes to the lane picked by addr[1:0]
            case (lane)
               2'b00: begin
                  aligned_wdata = {24'b0, store_src[7:0]};
               end
               2'b01: begin
                  aligned_wdata = {16'b0, store_src[7:0], 8'b0};
               end
               2'b10: begin
                  aligned_wdata = {8'b0, store_src[7:0], 16'b0};
               end
               default: begin
                  aligned_wdata = {store_src[7:0], 24'b0};
               end
            endcase
         end
         MEM_HALF: begin
            // only addr[1] matters, halfwords are aligned
            if (lane[1]) begin
               aligned_wdata = {store_src[15:0], 16'b0};
            end else begin
               aligned_wdata = {16'b0, store_src[15:0]};
            end
         end
         default: begin
            // full word
            aligned_wdata = store_src;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/lsu_data_phase.sv
// data phase tracker, keeps the attributes of the access whose data phase is on the bus
`default_nettype none

module lsu_data_phase (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               hreadyd,
   input  logic               htransd,
   input  logic               req_write,
   input  lsu_pkg::mem_size_e req_size,
   input  logic               req_unsigned,
   input  lsu_pkg::reg_idx_t  req_rd,
   input  lsu_pkg::lane_t     lane,
   input  lsu_pkg::reg_idx_t  req_rs2,
   output logic               dp_load,
   output lsu_pkg::mem_size_e dp_size,
   output logic               dp_unsigned,
   output lsu_pkg::lane_t     dp_lane,
   output lsu_pkg::reg_idx_t  dp_rd,
   output logic               fwd_hit
);

   import lsu_pkg::*;

   logic addr_done;

   // address phase completes on this edge
   assign addr_done = htransd & hreadyd;

   // ========================================
   // data phase registers
   // ========================================

   // a hreadyd-high edge always ends the current data phase,
   // so dp_load follows whatever is accepted on that edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_load <= 1'b0;
      end else if (hreadyd) begin
         dp_load <= htransd & ~req_write;
      end
   end

   // attributes needed by the load extraction
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_size     <= MEM_WORD;
         dp_unsigned <= 1'b0;
         dp_lane     <= '0;
         dp_rd       <= '0;
      end else if (addr_done) begin
         dp_size     <= req_size;
         dp_unsigned <= req_unsigned;
         dp_lane     <= lane;
         dp_rd       <= req_rd;
      end
   end

   // ========================================
   // load to store forwarding
   // ========================================

   // store in address phase reads the register the pending load
   // is about to write; the store only completes together with the
   // load data phase, so the extracted data is valid when it matters
   assign fwd_hit = dp_load & htransd & req_write & (req_rs2 == dp_rd);

endmodule

`default_nettype wire

// File: src/lsu_load_extract.sv
// load data extraction, picks the addressed byte or halfword from hrdatad and extends it
`default_nettype none

module lsu_load_extract (
   input  lsu_pkg::data_t     hrdatad,
   input  lsu_pkg::mem_size_e dp_size,
   input  logic               dp_unsigned,
   input  lsu_pkg::lane_t     dp_lane,
   output lsu_pkg::data_t     load_data
);

   import lsu_pkg::*;

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   logic        byte_fill;
   logic        half_fill;

   // ========================================
   // lane selection
   // ========================================

   always_comb begin
      case (dp_lane)
         2'b00: begin
            byte_sel = hrdatad[7:0];
         end
         2'b01: begin
            byte_sel = hrdatad[15:8];
         end
         2'b10: begin
            byte_sel = hrdatad[23:16];
         end
         default: begin
            byte_sel = hrdatad[31:24];
         end
      endcase
   end

   // halfword lane from addr[1]
   assign half_sel = dp_lane[1] ? hrdatad[31:16] : hrdatad[15:0];

   // sign bit, or zero for lbu / lhu
   assign byte_fill = byte_sel[7] & ~dp_unsigned;
   assign half_fill = half_sel[15] & ~dp_unsigned;

   // ========================================
   // extension
   // ========================================

   always_comb begin
      case (dp_size)
         MEM_BYTE: begin
            load_data = {{24{byte_fill}}, byte_sel};
         end
         MEM_HALF: begin
            load_data = {{16{half_fill}}, half_sel};
         end
         default: begin
            // word load, no extension
            load_data = hrdatad;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
// load/store unit top, drives the AHB-Lite data bus and returns load results as write-back
`default_nettype none

`include "lsu_defs.svh"

module lsu_top (
   input  logic                     clk,
   input  logic                     rst_n,
   // request from the execute side
   input  logic                     req_valid,
   input  logic                     req_write,
   input  lsu_pkg::mem_size_e       req_size,
   input  logic                     req_unsigned,
   input  lsu_pkg::addr_t           req_addr,
   input  lsu_pkg::data_t           req_wdata,
   input  lsu_pkg::reg_idx_t        req_rd,
   input  lsu_pkg::reg_idx_t        req_rs2,
   // data bus
   input  lsu_pkg::data_t           hrdatad,
   input  logic                     hreadyd,
   output lsu_pkg::addr_t           haddrd,
   output logic                     htransd,
   output logic                     hwrited,
   output logic [`LSU_HSIZE_W-1:0]  hsized,
   output lsu_pkg::data_t           hwdatad,
   // register write-back
   output logic                     wb_valid,
   output lsu_pkg::reg_idx_t        wb_rd,
   output lsu_pkg::data_t           wb_data
);

   import lsu_pkg::*;

   lane_t     lane;
   data_t     aligned_wdata;
   data_t     load_data;
   logic      fwd_hit;
   logic      dp_load;
   mem_size_e dp_size;
   logic      dp_unsigned;
   lane_t     dp_lane;

   // ========================================
   // address phase
   // ========================================

   assign htransd = req_valid;
   assign haddrd  = req_addr;
   assign hwrited = req_write;
   assign hsized  = req_size;

   assign lane = req_addr[`LSU_ADDR_LSB_W-1:0];

   lsu_data_phase u_data_phase (
      .clk          (clk),
      .rst_n        (rst_n),
      .hreadyd      (hreadyd),
      .htransd      (htransd),
      .req_write    (req_write),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_rd       (req_rd),
      .lane         (lane),
      .req_rs2      (req_rs2),
      .dp_load      (dp_load),
      .dp_size      (dp_size),
      .dp_unsigned  (dp_unsigned),
      .dp_lane      (dp_lane),
      .dp_rd        (wb_rd),
      .fwd_hit      (fwd_hit)
   );

   lsu_store_align u_store_align (
      .req_size      (req_size),
      .lane          (lane),
      .req_wdata     (req_wdata),
      .fwd_hit       (fwd_hit),
      .fwd_data      (load_data),
      .aligned_wdata (aligned_wdata)
   );

   // ========================================
   // data phase
   // ========================================

   // write data moves one cycle behind the address and holds
   // through wait states
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwdatad <= {`LSU_DATA_W{1'b0}};
      end else if (htransd & hreadyd) begin
         hwdatad <= aligned_wdata;
      end
   end

   lsu_load_extract u_load_extract (
      .hrdatad     (hrdatad),
      .dp_size     (dp_size),
      .dp_unsigned (dp_unsigned),
      .dp_lane     (dp_lane),
      .load_data   (load_data)
   );

   // load result is valid only in the cycle the slave is ready
   assign wb_valid = dp_load & hreadyd;
   assign wb_data  = load_data;

endmodule

`default_nettype wire

// File: bench/lsu_tb.sv
// testbench for the load/store unit, replays bench/lsu_input.dat against a bus memory model
`default_nettype none

`include "lsu_defs.svh"

module lsu_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import lsu_pkg::*;

   // ========================================
   // DUT signals
   // ========================================

   logic                    clk;
   logic                    rst_n;
   logic                    req_valid;
   logic                    req_write;
   mem_size_e               req_size;
   logic                    req_unsigned;
   addr_t                   req_addr;
   data_t                   req_wdata;
   reg_idx_t                req_rd;
   reg_idx_t                req_rs2;
   data_t                   hrdatad;
   logic                    hreadyd;
   addr_t                   haddrd;
   logic                    htransd;
   logic                    hwrited;
   logic [`LSU_HSIZE_W-1:0] hsized;
   data_t                   hwdatad;
   logic                    wb_valid;
   reg_idx_t                wb_rd;
   data_t                   wb_data;

   // accesses read from the data file
   logic      acc_write[$];
   mem_size_e acc_size[$];
   logic      acc_unsigned[$];
   addr_t     acc_addr[$];
   data_t     acc_wdata[$];
   reg_idx_t  acc_rd[$];
   reg_idx_t  acc_rs2[$];
   int        acc_wait[$];
   data_t     acc_exp[$];
   logic      acc_done[$];

   // bus memory model, 16 words
   data_t  mem [0:15];
   int     n_acc = 0;
   int     next_idx = 0;
   int     dp_idx = -1;
   int     wait_left = 0;
   int     done_count = 0;
   int     limit_cycles = 0;
   integer seed = 43;
   logic   hold_seen = 1'b0;
   data_t  held_wdata;

   lsu_top u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_write    (req_write),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_addr     (req_addr),
      .req_wdata    (req_wdata),
      .req_rd       (req_rd),
      .req_rs2      (req_rs2),
      .hrdatad      (hrdatad),
      .hreadyd      (hreadyd),
      .haddrd       (haddrd),
      .htransd      (htransd),
      .hwrited      (hwrited),
      .hsized       (hsized),
      .hwdatad      (hwdatad),
      .wb_valid     (wb_valid),
      .wb_rd        (wb_rd),
      .wb_data      (wb_data)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // ========================================
   // reporting and compare tasks
   // ========================================

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_data(data_t got, data_t exp, string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_rd(reg_idx_t got, reg_idx_t exp, string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got x%0d expected x%0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_size(mem_size_e got, mem_size_e exp, string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got %b expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   // ========================================
   // data file and memory helpers
   // ========================================

   task automatic read_accesses();
      int          fd;
      int          max_wait;
      string       line;
      logic [31:0] fld [9];
      max_wait = 0;
      fd = $fopen("bench/lsu_input.dat", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file bench/lsu_input.dat");
         abort_run();
      end
      while ($fgets(line, fd) > 0) begin
         // skip comment and blank lines
         if (line.len() > 1 && line[0] != "#") begin
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                        fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]) != 9) begin
               $display("malformed line in the stimulus file: %s", line);
               abort_run();
            end
            acc_write.push_back(fld[0][0]);
            acc_size.push_back(mem_size_e'(fld[1][2:0]));
            acc_unsigned.push_back(fld[2][0]);
            acc_addr.push_back(fld[3]);
            acc_wdata.push_back(fld[4]);
            acc_rd.push_back(fld[5][4:0]);
            acc_rs2.push_back(fld[6][4:0]);
            acc_wait.push_back(int'(fld[7]));
            acc_exp.push_back(fld[8]);
            acc_done.push_back(1'b0);
            if (int'(fld[7]) > max_wait) begin
               max_wait = int'(fld[7]);
            end
         end
      end
      $fclose(fd);
      n_acc = acc_write.size();
      if (n_acc == 0) begin
         $display("the stimulus file holds no accesses");
         abort_run();
      end
      limit_cycles = n_acc * (max_wait + 4) + 20;
   endtask

   function automatic logic [3:0] mem_index(addr_t a);
      return a[5:2];
   endfunction

   // byte lanes written by a store of this size at this lane
   function automatic data_t lane_mask(mem_size_e size, lane_t lane);
      case (size)
         MEM_BYTE: return 32'h0000_00ff << (8 * lane);
         MEM_HALF: return 32'h0000_ffff << (16 * lane[1]);
         default:  return 32'hffff_ffff;
      endcase
   endfunction

   // ========================================
   // bus cycle model
   // ========================================

   // slave wait states, read data and the request side
   task automatic drive_cycle();
      if (dp_idx >= 0 && wait_left > 0) begin
         hreadyd = 1'b0;
         wait_left--;
      end else begin
         hreadyd = 1'b1;
      end
      // inverted junk while not ready, must never reach wb_data
      if (dp_idx >= 0 && !acc_write[dp_idx]) begin
         if (hreadyd) begin
            hrdatad = mem[mem_index(acc_addr[dp_idx])];
         end else begin
            hrdatad = ~mem[mem_index(acc_addr[dp_idx])];
         end
      end else begin
         hrdatad = '0;
      end
      if (next_idx < n_acc) begin
         req_valid    = 1'b1;
         req_write    = acc_write[next_idx];
         req_size     = acc_size[next_idx];
         req_unsigned = acc_unsigned[next_idx];
         req_addr     = acc_addr[next_idx];
         req_wdata    = acc_wdata[next_idx];
         req_rd       = acc_rd[next_idx];
         req_rs2      = acc_rs2[next_idx];
      end else begin
         req_valid = 1'b0;
      end
   endtask

   task automatic complete_access();
      data_t mask;
      logic [3:0] idx;
      if (acc_done[dp_idx]) begin
         $display("access %0d completed a second time", dp_idx);
         abort_run();
      end
      acc_done[dp_idx] = 1'b1;
      done_count++;
      idx = mem_index(acc_addr[dp_idx]);
      if (acc_write[dp_idx]) begin
         check_flag(wb_valid, 1'b0, "wb_valid on a store");
         mask = lane_mask(acc_size[dp_idx], acc_addr[dp_idx][1:0]);
         check_data(hwdatad & ~mask, '0, "unused store lanes");
         mem[idx] = (mem[idx] & ~mask) | (hwdatad & mask);
         check_data(mem[idx], acc_exp[dp_idx], "memory word after store");
      end else begin
         check_flag(wb_valid, 1'b1, "wb_valid on load completion");
         check_rd(wb_rd, acc_rd[dp_idx], "wb_rd");
         check_data(wb_data, acc_exp[dp_idx], "wb_data");
      end
   endtask

   task automatic sample_cycle();
      check_flag(htransd, req_valid, "htransd");
      if (req_valid) begin
         check_data(haddrd, req_addr, "haddrd");
         check_flag(hwrited, req_write, "hwrited");
         check_size(mem_size_e'(hsized), req_size, "hsized");
      end
      if (dp_idx < 0) begin
         check_flag(wb_valid, 1'b0, "wb_valid with no data phase");
      end else begin
         // write data frozen for the whole data phase
         if (!hold_seen) begin
            held_wdata = hwdatad;
            hold_seen  = 1'b1;
         end else begin
            check_data(hwdatad, held_wdata, "hwdatad during data phase");
         end
         if (!hreadyd) begin
            check_flag(wb_valid, 1'b0, "wb_valid in a wait state");
         end else begin
            complete_access();
         end
      end
   endtask

   // what the clock edge did to the two pipeline phases
   task automatic advance_pipeline();
      integer extra;
      if (dp_idx >= 0 && hreadyd) begin
         dp_idx = -1;
      end
      if (req_valid && hreadyd) begin
         dp_idx = next_idx;
         next_idx++;
         extra = $random(seed);
         wait_left = acc_wait[dp_idx] + (extra & 1);
         hold_seen = 1'b0;
      end
   endtask

   // ========================================
   // main sequence
   // ========================================

   initial begin
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req_write    = 1'b0;
      req_size     = MEM_WORD;
      req_unsigned = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      req_rd       = '0;
      req_rs2      = '0;
      hrdatad      = '0;
      hreadyd      = 1'b1;
      for (int i = 0; i < 16; i++) begin
         mem[i] = 32'h8040_2010 ^ (32'h0101_0101 * i);
      end
      read_accesses();
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      check_flag(wb_valid, 1'b0, "wb_valid after reset");
      check_data(hwdatad, '0, "hwdatad after reset");
      while (done_count < n_acc) begin
         @(posedge clk);
         advance_pipeline();
         #2;
         drive_cycle();
         @(negedge clk);
         sample_cycle();
      end
      $display("RESULT: PASS");
      $finish;
   end

   // watchdog
   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: accesses not finished after %0d clock cycles", limit_cycles);
      abort_run();
   end

endmodule

`default_nettype wire

// File: bench/lsu_input.dat
# columns: write size unsigned address wdata rd rs2 waits expected (hex)
# expected is the memory word after a store, or wb_data for a load
1 2 0 00000020 876543a1 00 01 0 876543a1
1 2 0 00000024 12f480ff 00 02 1 12f480ff
1 2 0 00000028 00000000 00 03 2 00000000
1 2 0 0000002c ffffffff 00 04 0 ffffffff
1 0 0 00000028 aaaaaa11 00 05 0 00000011
1 0 0 00000029 12345622 00 06 1 00002211
1 0 0 0000002a 00000033 00 07 3 00332211
1 0 0 0000002b ffffff94 00 08 0 94332211
1 1 0 0000002c dead5a6b 00 09 0 ffff5a6b
1 1 0 0000002e 0000c7e8 00 0a 1 c7e85a6b
0 0 0 00000020 00000000 01 00 0 ffffffa1
0 0 1 00000020 00000000 02 00 1 000000a1
0 0 0 00000021 00000000 03 00 2 00000043
0 0 1 00000022 00000000 04 00 0 00000065
0 0 0 00000023 00000000 05 00 0 ffffff87
0 0 1 00000023 00000000 06 00 1 00000087
0 1 0 00000024 00000000 0d 00 0 ffff80ff
0 1 1 00000024 00000000 0e 00 2 000080ff
0 1 0 00000026 00000000 0f 00 0 000012f4
0 1 1 0000002e 00000000 10 00 1 0000c7e8
0 1 0 0000002e 00000000 11 00 0 ffffc7e8
0 2 0 00000028 00000000 12 00 1 94332211
0 2 0 00000020 00000000 07 00 2 876543a1
1 2 0 00000030 11111111 00 07 0 876543a1
0 0 1 00000023 00000000 09 00 0 00000087
1 0 0 00000031 55555555 00 09 1 876587a1
0 1 0 00000024 00000000 0b 00 3 ffff80ff
1 1 0 00000032 00000000 00 0b 0 80ff87a1
0 2 0 00000030 00000000 0c 00 0 80ff87a1
1 2 0 00000034 0badf00d 00 0d 1 0badf00d
0 2 1 00000034 00000000 13 00 0 0badf00d

// File: lsu.f
+incdir+src
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_data_phase.sv
src/lsu_load_extract.sv
src/lsu_top.sv
bench/lsu_tb.sv

// File: Makefile
# Verilator flow for the load/store unit: lint, simulate, clean

VERILATOR  ?= verilator
TOP        ?= lsu_tb
RTL_TOP    ?= lsu_top
FILELIST   ?= lsu.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= RESULT: PASS

RTL_SRCS = src/lsu_pkg.sv \
           src/lsu_store_align.sv \
           src/lsu_data_phase.sv \
           src/lsu_load_extract.sv \
           src/lsu_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+src --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
